// ==== cp0_macros.svh ====
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// CP0 register numbers
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// ExcCode values written into CAUSE[6:2]
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_OV   5'd12
`define EXC_TR   5'd13

// BEV set out of reset
`define STATUS_RESET 32'h0040_0000
`define CONFIG_RESET 32'h0000_8000
`define PRID_VALUE   32'h004c_0102

`define STATUS_WMASK 32'h0000_ff01
`define CAUSE_WMASK  32'h0000_0300

`define DS_PC_OFFSET 32'd4

`endif

// ==== cp0_pkg.sv ====
package cp0_pkg;

	// MTC0 write request
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} cp0_wr_t;

	// Commit from the memory stage, eret is a commit of its own kind
	typedef struct packed {
		logic        valid;
		logic        eret;
		logic [4:0]  code;
		logic        in_delay;
		logic [31:0] pc;
		logic [31:0] bad_addr;
		logic        has_bad_addr;
	} cp0_exc_t;

	typedef struct packed {
		logic [8:0] rsv_31_23;
		logic       bev;
		logic [5:0] rsv_21_16;
		logic [7:0] im;
		logic [5:0] rsv_7_2;
		logic       exl;
		logic       ie;
	} cp0_status_fields_t;

	// STATUS as a raw word or as its fields
	typedef union packed {
		logic [31:0]        word;
		cp0_status_fields_t fields;
	} cp0_status_u;

endpackage

// ==== cp0_timer.sv ====
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0_timer (
	input  logic             clk,
	input  logic             rst_n_i,
	input  cp0_pkg::cp0_wr_t wr_i,
	output logic [31:0]      count_o,
	output logic [31:0]      compare_o,
	output logic             timer_int_o
);

	logic [31:0] count_q;
	logic [31:0] compare_q;
	logic        timer_int_q;
	logic        count_we;
	logic        compare_we;
	logic        match;

	assign count_we   = wr_i.we && (wr_i.addr == `CP0_REG_COUNT);
	assign compare_we = wr_i.we && (wr_i.addr == `CP0_REG_COMPARE);

	// A zero COMPARE never fires
	assign match = (compare_q != 32'd0) && (count_q == compare_q);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q     <= 32'd0;
			compare_q   <= 32'd0;
			timer_int_q <= 1'b0;
		end else begin
			if (count_we) begin
				count_q <= wr_i.data;
			end else begin
				count_q <= count_q + 32'd1;
			end

			if (compare_we) begin
				compare_q   <= wr_i.data;
				timer_int_q <= 1'b0;
			end else if (match) begin
				timer_int_q <= 1'b1;
			end
		end
	end

	assign count_o     = count_q;
	assign compare_o   = compare_q;
	assign timer_int_o = timer_int_q;

endmodule

// ==== cp0_exc_state.sv ====
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0_exc_state (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic [5:0]           int_i,
	input  cp0_pkg::cp0_wr_t     wr_i,
	input  cp0_pkg::cp0_exc_t    exc_i,
	output cp0_pkg::cp0_status_u status_o,
	output logic [31:0]          cause_o,
	output logic [31:0]          epc_o,
	output logic [31:0]          badvaddr_o
);

	cp0_pkg::cp0_status_u status_q;
	cp0_pkg::cp0_status_u status_d;
	logic [31:0]          cause_q;
	logic [31:0]          cause_d;
	logic [31:0]          epc_q;
	logic [31:0]          epc_d;
	logic [31:0]          badvaddr_q;
	logic [31:0]          badvaddr_d;
	logic                 exc_take;
	logic                 eret_take;
	logic [31:0]          exc_epc;

	assign exc_take  = exc_i.valid && !exc_i.eret;
	assign eret_take = exc_i.valid && exc_i.eret;

	// Branch address when the faulting instruction is in a delay slot
	assign exc_epc = exc_i.in_delay ? (exc_i.pc - `DS_PC_OFFSET) : exc_i.pc;

	always_comb begin
		status_d   = status_q;
		cause_d    = cause_q;
		epc_d      = epc_q;
		badvaddr_d = badvaddr_q;

		// IP7:2 track the hardware lines
		cause_d[15:10] = int_i;

		if (wr_i.we) begin
			case (wr_i.addr)
				`CP0_REG_STATUS: begin
					status_d.word = (status_q.word & ~`STATUS_WMASK) |
						(wr_i.data & `STATUS_WMASK);
				end
				`CP0_REG_CAUSE: begin
					cause_d = (cause_d & ~`CAUSE_WMASK) | (wr_i.data & `CAUSE_WMASK);
				end
				`CP0_REG_EPC: begin
					epc_d = wr_i.data;
				end
				default: begin
				end
			endcase
		end

		// Commit overrides a same-cycle MTC0
		if (exc_take) begin
			status_d.fields.exl = 1'b1;
			cause_d[31]         = exc_i.in_delay;
			cause_d[6:2]        = exc_i.code;
			epc_d               = exc_epc;
			if (exc_i.has_bad_addr) begin
				badvaddr_d = exc_i.bad_addr;
			end
		end else if (eret_take) begin
			status_d.fields.exl = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			status_q.word <= `STATUS_RESET;
			cause_q       <= 32'd0;
			epc_q         <= 32'd0;
			badvaddr_q    <= 32'd0;
		end else begin
			status_q   <= status_d;
			cause_q    <= cause_d;
			epc_q      <= epc_d;
			badvaddr_q <= badvaddr_d;
		end
	end

	assign status_o   = status_q;
	assign cause_o    = cause_q;
	assign epc_o      = epc_q;
	assign badvaddr_o = badvaddr_q;

endmodule

// ==== cp0_read_port.sv ====
`timescale 1ns/1ps
`include "cp0_macros.svh"

module cp0_read_port (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 rd_req_i,
	input  logic [4:0]           rd_addr_i,
	output logic                 rd_ack_o,
	output logic [31:0]          rd_data_o,
	input  logic [31:0]          count_i,
	input  logic [31:0]          compare_i,
	input  cp0_pkg::cp0_status_u status_i,
	input  logic [31:0]          cause_i,
	input  logic [31:0]          epc_i,
	input  logic [31:0]          badvaddr_i,
	input  logic                 timer_int_i,
	output logic                 int_pending_o
);

	logic [31:0] cause_merged;
	logic [31:0] rd_mux;
	logic        rd_ack_q;
	logic [31:0] rd_data_q;
	logic        rd_take;

	// Timer interrupt shares IP7 with hardware line 5
	always_comb begin
		cause_merged     = cause_i;
		cause_merged[15] = cause_i[15] | timer_int_i;
	end

	assign int_pending_o = (|(cause_merged[15:8] & status_i.fields.im)) &
		status_i.fields.ie & ~status_i.fields.exl;

	always_comb begin
		case (rd_addr_i)
			`CP0_REG_COUNT:    rd_mux = count_i;
			`CP0_REG_COMPARE:  rd_mux = compare_i;
			`CP0_REG_STATUS:   rd_mux = status_i.word;
			`CP0_REG_CAUSE:    rd_mux = cause_merged;
			`CP0_REG_EPC:      rd_mux = epc_i;
			`CP0_REG_PRID:     rd_mux = `PRID_VALUE;
			`CP0_REG_CONFIG:   rd_mux = `CONFIG_RESET;
			`CP0_REG_BADVADDR: rd_mux = badvaddr_i;
			default:           rd_mux = 32'd0;
		endcase
	end

	// New request only once the previous ack has dropped
	assign rd_take = rd_req_i && !rd_ack_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_ack_q <= 1'b0;
		end else if (rd_take) begin
			rd_ack_q <= 1'b1;
		end else if (!rd_req_i) begin
			rd_ack_q <= 1'b0;
		end
	end

	// Snapshot held through back-pressure
	always_ff @(posedge clk) begin
		if (rd_take) begin
			rd_data_q <= rd_mux;
		end
	end

	assign rd_ack_o  = rd_ack_q;
	assign rd_data_o = rd_data_q;

endmodule

// ==== cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic [5:0]        int_i,
	input  cp0_pkg::cp0_wr_t  wr_i,
	input  cp0_pkg::cp0_exc_t exc_i,
	input  logic              rd_req_i,
	input  logic [4:0]        rd_addr_i,
	output logic              rd_ack_o,
	output logic [31:0]       rd_data_o,
	output logic [31:0]       epc_o,
	output logic              int_pending_o,
	output logic              timer_int_o
);

	logic [31:0]          count;
	logic [31:0]          compare;
	logic                 timer_int;
	cp0_pkg::cp0_status_u status;
	logic [31:0]          cause;
	logic [31:0]          epc;
	logic [31:0]          badvaddr;

	cp0_timer timer_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.wr_i        (wr_i),
		.count_o     (count),
		.compare_o   (compare),
		.timer_int_o (timer_int)
	);

	cp0_exc_state exc_state_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.int_i      (int_i),
		.wr_i       (wr_i),
		.exc_i      (exc_i),
		.status_o   (status),
		.cause_o    (cause),
		.epc_o      (epc),
		.badvaddr_o (badvaddr)
	);

	cp0_read_port read_port_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.rd_req_i      (rd_req_i),
		.rd_addr_i     (rd_addr_i),
		.rd_ack_o      (rd_ack_o),
		.rd_data_o     (rd_data_o),
		.count_i       (count),
		.compare_i     (compare),
		.status_i      (status),
		.cause_i       (cause),
		.epc_i         (epc),
		.badvaddr_i    (badvaddr),
		.timer_int_i   (timer_int),
		.int_pending_o (int_pending_o)
	);

	// ERET target for the core
	assign epc_o       = epc;
	assign timer_int_o = timer_int;

endmodule

// ==== tb_cp0.sv ====
`timescale 1ns/1ps
`include "cp0_macros.svh"

module tb_cp0;

	localparam logic [2:0] op_wr   = 3'd0;
	localparam logic [2:0] op_exc  = 3'd1;
	localparam logic [2:0] op_eret = 3'd2;
	localparam logic [2:0] op_rd   = 3'd3;
	localparam logic [2:0] op_idle = 3'd4;
	localparam logic [2:0] op_int  = 3'd5;
	localparam logic [2:0] op_flag = 3'd6;

	// Field sel holds a register number or ExcCode and a holds data, PC or cycles
	// Field b carries the bad address and bits carries {has_bad_addr, in_delay}
	// Field exp holds read data, the new EPC or {pending, timer}
	typedef struct packed {
		logic [2:0]  op;
		logic [4:0]  sel;
		logic [31:0] a;
		logic [31:0] b;
		logic [1:0]  bits;
		logic [31:0] exp;
	} row_t;

	logic              clk;
	logic              rst_n_i;
	logic [5:0]        int_i;
	cp0_pkg::cp0_wr_t  wr_i;
	cp0_pkg::cp0_exc_t exc_i;
	logic              rd_req_i;
	logic [4:0]        rd_addr_i;
	logic              rd_ack_o;
	logic [31:0]       rd_data_o;
	logic [31:0]       epc_o;
	logic              int_pending_o;
	logic              timer_int_o;
	row_t              rows[$];

	cp0_top dut_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.int_i         (int_i),
		.wr_i          (wr_i),
		.exc_i         (exc_i),
		.rd_req_i      (rd_req_i),
		.rd_addr_i     (rd_addr_i),
		.rd_ack_o      (rd_ack_o),
		.rd_data_o     (rd_data_o),
		.epc_o         (epc_o),
		.int_pending_o (int_pending_o),
		.timer_int_o   (timer_int_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		assert (act_val === exp_val) else fail_run($sformatf(
			"[FAIL] time %0t: %s expected %h, got %h", $time, name, exp_val, act_val));
	endtask

	task automatic add_row(input logic [2:0] op, input logic [4:0] sel, input logic [31:0] a,
		input logic [31:0] b, input logic [1:0] bits, input logic [31:0] exp);
		rows.push_back('{op, sel, a, b, bits, exp});
	endtask

	// Four-phase read with an optional hold of the request
	task automatic do_read(input logic [4:0] addr, input logic [31:0] exp,
		input logic [31:0] hold);
		int waited;
		@(posedge clk);
		#1;
		rd_req_i  = 1'b1;
		rd_addr_i = addr;
		waited    = 0;
		while (!rd_ack_o && waited < 8) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (rd_ack_o) else fail_run($sformatf("Read of register %0d got no ack", addr));
		check_value("rd_data_o", exp, rd_data_o);
		repeat (hold) begin
			@(posedge clk);
			#1;
			check_value("rd_ack_o", 32'd1, {31'd0, rd_ack_o});
			check_value("rd_data_o", exp, rd_data_o);
		end
		rd_req_i = 1'b0;
		@(posedge clk);
		#1;
		check_value("rd_ack_o", 32'd0, {31'd0, rd_ack_o});
	endtask

	task automatic build_table();
		add_row(op_rd, `CP0_REG_STATUS, 0, 0, 2'b00, 32'h0040_0000);
		add_row(op_rd, `CP0_REG_PRID, 0, 0, 2'b00, `PRID_VALUE);
		add_row(op_rd, `CP0_REG_CONFIG, 0, 0, 2'b00, `CONFIG_RESET);
		add_row(op_rd, 5'd3, 0, 0, 2'b00, 32'h0);
		add_row(op_wr, `CP0_REG_STATUS, 32'hffff_ffff, 0, 2'b00, 0);
		add_row(op_rd, `CP0_REG_STATUS, 0, 0, 2'b00, 32'h0040_ff01);
		add_row(op_wr, `CP0_REG_CAUSE, 32'hffff_ffff, 0, 2'b00, 0);
		add_row(op_rd, `CP0_REG_CAUSE, 0, 0, 2'b00, 32'h0000_0300);
		add_row(op_wr, `CP0_REG_EPC, 32'h1234_5678, 0, 2'b00, 0);
		add_row(op_rd, `CP0_REG_EPC, 0, 0, 2'b00, 32'h1234_5678);
		add_row(op_wr, `CP0_REG_CAUSE, 32'h0, 0, 2'b00, 0);
		add_row(op_flag, 0, 0, 0, 2'b00, 32'h0);
		// Ordinary, delay-slot and address-error commits
		add_row(op_exc, `EXC_SYS, 32'h8000_0100, 32'hdead_0000, 2'b00, 32'h8000_0100);
		add_row(op_rd, `CP0_REG_EPC, 0, 0, 2'b00, 32'h8000_0100);
		add_row(op_rd, `CP0_REG_CAUSE, 0, 0, 2'b00, 32'h0000_0020);
		add_row(op_rd, `CP0_REG_STATUS, 0, 0, 2'b00, 32'h0040_ff03);
		add_row(op_rd, `CP0_REG_BADVADDR, 0, 0, 2'b00, 32'h0);
		add_row(op_eret, 0, 0, 0, 2'b00, 0);
		add_row(op_rd, `CP0_REG_STATUS, 0, 0, 2'b00, 32'h0040_ff01);
		add_row(op_exc, `EXC_ADEL, 32'h8000_0204, 32'h0000_1003, 2'b11, 32'h8000_0200);
		add_row(op_rd, `CP0_REG_EPC, 0, 0, 2'b00, 32'h8000_0200);
		add_row(op_rd, `CP0_REG_CAUSE, 0, 0, 2'b00, 32'h8000_0010);
		add_row(op_rd, `CP0_REG_BADVADDR, 0, 0, 2'b00, 32'h0000_1003);
		add_row(op_exc, `EXC_ADES, 32'h8000_0300, 32'h0000_2001, 2'b10, 32'h8000_0300);
		add_row(op_rd, `CP0_REG_CAUSE, 0, 0, 2'b00, 32'h0000_0014);
		add_row(op_rd, `CP0_REG_BADVADDR, 0, 0, 2'b00, 32'h0000_2001);
		add_row(op_exc, `EXC_OV, 32'h8000_0400, 32'hffff_fff0, 2'b01, 32'h8000_03fc);
		add_row(op_rd, `CP0_REG_EPC, 0, 0, 2'b00, 32'h8000_03fc);
		add_row(op_rd, `CP0_REG_CAUSE, 0, 0, 2'b00, 32'h8000_0030);
		add_row(op_rd, `CP0_REG_BADVADDR, 0, 0, 2'b00, 32'h0000_2001);
		add_row(op_eret, 0, 0, 0, 2'b00, 0);
		// Timer match at 40 and flag clear on a COMPARE write
		add_row(op_wr, `CP0_REG_COMPARE, 32'd40, 0, 2'b00, 0);
		add_row(op_wr, `CP0_REG_COUNT, 32'd0, 0, 2'b00, 0);
		add_row(op_idle, 0, 32'd50, 0, 2'b00, 0);
		add_row(op_flag, 0, 0, 0, 2'b00, 32'h3);
		add_row(op_rd, `CP0_REG_CAUSE, 0, 0, 2'b00, 32'h8000_8030);
		add_row(op_wr, `CP0_REG_COMPARE, 32'd0, 0, 2'b00, 0);
		add_row(op_flag, 0, 0, 0, 2'b00, 32'h0);
		// Hardware line 2 lands on IP4
		add_row(op_int, 0, 32'h04, 0, 2'b00, 0);
		add_row(op_flag, 0, 0, 0, 2'b00, 32'h2);
		add_row(op_exc, `EXC_BP, 32'h8000_0500, 32'h0, 2'b00, 32'h8000_0500);
		add_row(op_flag, 0, 0, 0, 2'b00, 32'h0);
		add_row(op_rd, `CP0_REG_CAUSE, 0, 0, 2'b00, 32'h0000_1024);
		add_row(op_eret, 0, 0, 0, 2'b00, 0);
		add_row(op_flag, 0, 0, 0, 2'b00, 32'h2);
		add_row(op_rd, `CP0_REG_EPC, 32'd5, 0, 2'b00, 32'h8000_0500);
	endtask

	initial begin
		@(posedge rst_n_i);
		repeat (rows.size() * 20 + 100) @(posedge clk);
		fail_run("Timeout: the test table did not finish in time");
	end

	initial begin
		row_t r;
		int_i     = 6'd0;
		wr_i      = '0;
		exc_i     = '0;
		rd_req_i  = 1'b0;
		rd_addr_i = 5'd0;
		rst_n_i   = 1'b0;
		build_table();
		repeat (4) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		foreach (rows[i]) begin
			r = rows[i];
			case (r.op)
				op_wr: begin
					@(posedge clk);
					#1;
					wr_i = '{1'b1, r.sel, r.a};
					@(posedge clk);
					#1;
					wr_i.we = 1'b0;
				end
				op_exc, op_eret: begin
					@(posedge clk);
					#1;
					exc_i = '{1'b1, r.op == op_eret, r.sel, r.bits[0], r.a, r.b, r.bits[1]};
					@(posedge clk);
					#1;
					exc_i.valid = 1'b0;
					if (r.op == op_exc) begin
						check_value("epc_o", r.exp, epc_o);
					end
				end
				op_rd: do_read(r.sel, r.exp, r.a);
				op_idle: repeat (r.a) @(posedge clk);
				op_int: begin
					@(posedge clk);
					#1;
					int_i = r.a[5:0];
				end
				default: begin
					@(posedge clk);
					#1;
					check_value("timer_int_o", {31'd0, r.exp[0]}, {31'd0, timer_int_o});
					check_value("int_pending_o", {31'd0, r.exp[1]}, {31'd0, int_pending_o});
				end
			endcase
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
cp0_pkg.sv
cp0_timer.sv
cp0_exc_state.sv
cp0_read_port.sv
cp0_top.sv
tb_cp0.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_cp0 -o tb_cp0_sim
	./obj_dir/tb_cp0_sim | tee /dev/stderr | grep "Result: PASSED" > /dev/null

clean:
	rm -rf obj_dir
